// File: logic/glb_pkg.sv
// shared sizes, address fields, lane packet types and host states for the global buffer
package glb_pkg;

    // chain geometry
    localparam int num_tiles = 4;
    localparam int tile_sel_width = 2;
    localparam int bank_addr_width = 4;
    localparam int data_width = 32;

    // read watchdog limit, in raw clock cycles
    localparam int rd_timeout_cycles = 40;

    // tile select sits above the bank address
    typedef logic [tile_sel_width-1:0] tile_sel_t;
    typedef logic [bank_addr_width-1:0] bank_addr_t;
    typedef logic [tile_sel_width+bank_addr_width-1:0] glb_addr_t;
    typedef logic [data_width-1:0] glb_data_t;

    // write request
    typedef struct packed {
        logic wr_en;
        glb_addr_t wr_addr;
        glb_data_t wr_data;
    } wr_packet_t;

    // read request
    typedef struct packed {
        logic rd_en;
        glb_addr_t rd_addr;
    } rdrq_packet_t;

    // read response, carried back toward the host
    typedef struct packed {
        logic rd_data_valid;
        glb_data_t rd_data;
    } rdrs_packet_t;

    // one lane of the tile chain
    typedef struct packed {
        wr_packet_t wr;
        rdrq_packet_t rdrq;
        rdrs_packet_t rdrs;
    } packet_t;

    // host FSM
    typedef enum logic {
        host_idle,
        host_wait_rsp
    } host_state_t;

endpackage

// File: logic/glb_proc_router.sv
// per-tile router: registers the served lane, passes the other lane, inserts bank responses
`timescale 1ns/1ps

module glb_proc_router #(
    parameter int tile_id = 0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_en,
    input  glb_pkg::packet_t      packet_w2e_wsti,
    input  glb_pkg::packet_t      packet_e2w_esti,
    output glb_pkg::packet_t      packet_w2e_esto,
    output glb_pkg::packet_t      packet_e2w_wsto,
    output glb_pkg::wr_packet_t   wr_packet,
    output glb_pkg::rdrq_packet_t rdrq_packet,
    input  glb_pkg::rdrs_packet_t rdrs_packet
);
    import glb_pkg::*;

    // even tiles serve west-to-east, odd tiles east-to-west
    logic is_even;

    packet_t own_in;
    packet_t own_q;
    packet_t own_out;
    rdrs_packet_t rsp_q;

    assign is_even = (tile_id % 2 == 0);

    // served lane input
    assign own_in = is_even ? packet_w2e_wsti : packet_e2w_esti;

    // one stage on the served lane
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            own_q <= '0;
        end else if (clk_en) begin
            own_q <= own_in;
        end
    end

    // bank response held one clk_en cycle before insertion
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_q <= '0;
        end else if (clk_en) begin
            rsp_q <= rdrs_packet;
        end
    end

    // requests go on unchanged, response slot taken when our bank answers
    always_comb begin
        own_out.wr = own_q.wr;
        own_out.rdrq = own_q.rdrq;
        own_out.rdrs = rsp_q.rd_data_valid ? rsp_q : own_q.rdrs;
    end

    // other lane is plain wires
    assign packet_w2e_esto = is_even ? own_out : packet_w2e_wsti;
    assign packet_e2w_wsto = is_even ? packet_e2w_esti : own_out;

    // bank sees the registered requests
    assign wr_packet = own_q.wr;
    assign rdrq_packet = own_q.rdrq;

    // only one read in flight chain-wide, so the response slot is always free
    rsp_no_collision: assert property (
        @(posedge clk) disable iff (reset)
        !(rsp_q.rd_data_valid && own_q.rdrs.rd_data_valid)
    );

endmodule

// File: logic/glb_bank_switch.sv
// per-tile memory bank: serves writes and reads aimed at this tile, registered read response
`timescale 1ns/1ps

module glb_bank_switch #(
    parameter int tile_id = 0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_en,
    input  glb_pkg::wr_packet_t   wr_packet,
    input  glb_pkg::rdrq_packet_t rdrq_packet,
    output glb_pkg::rdrs_packet_t rdrs_packet
);
    import glb_pkg::*;

    glb_data_t mem [2**bank_addr_width];

    logic wr_hit;
    logic rd_hit;
    bank_addr_t wr_word;
    bank_addr_t rd_word;

    // address split, tile select on top
    assign wr_word = bank_addr_t'(wr_packet.wr_addr);
    assign rd_word = bank_addr_t'(rdrq_packet.rd_addr);

    assign wr_hit = wr_packet.wr_en
        && (tile_sel_t'(wr_packet.wr_addr >> bank_addr_width) == tile_sel_t'(tile_id));
    assign rd_hit = rdrq_packet.rd_en
        && (tile_sel_t'(rdrq_packet.rd_addr >> bank_addr_width) == tile_sel_t'(tile_id));

    // bank starts out cleared
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**bank_addr_width; i++) begin
                mem[i] <= '0;
            end
        end else if (clk_en && wr_hit) begin
            mem[wr_word] <= wr_packet.wr_data;
        end
    end

    // response one clk_en cycle after the request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrs_packet <= '0;
        end else if (clk_en) begin
            rdrs_packet.rd_data_valid <= rd_hit;
            rdrs_packet.rd_data <= mem[rd_word];
        end
    end

    // host sends one packet at a time, so a write and read never meet here
    no_wr_rd_overlap: assert property (
        @(posedge clk) disable iff (reset)
        !(wr_hit && rd_hit)
    );

endmodule

// File: logic/glb_tile.sv
// one buffer tile: router plus bank, placed in the chain by its tile position
`timescale 1ns/1ps

module glb_tile #(
    parameter int tile_id = 0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             clk_en,
    input  glb_pkg::packet_t packet_w2e_wsti,
    input  glb_pkg::packet_t packet_e2w_esti,
    output glb_pkg::packet_t packet_w2e_esto,
    output glb_pkg::packet_t packet_e2w_wsto
);
    import glb_pkg::*;

    // router to bank
    wr_packet_t wr_packet;
    rdrq_packet_t rdrq_packet;
    // bank to router
    rdrs_packet_t rdrs_packet;

    glb_proc_router #(
        .tile_id(tile_id)
    ) i_router (
        .clk(clk),
        .reset(reset),
        .clk_en(clk_en),
        .packet_w2e_wsti(packet_w2e_wsti),
        .packet_e2w_esti(packet_e2w_esti),
        .packet_w2e_esto(packet_w2e_esto),
        .packet_e2w_wsto(packet_e2w_wsto),
        .wr_packet(wr_packet),
        .rdrq_packet(rdrq_packet),
        .rdrs_packet(rdrs_packet)
    );

    glb_bank_switch #(
        .tile_id(tile_id)
    ) i_bank (
        .clk(clk),
        .reset(reset),
        .clk_en(clk_en),
        .wr_packet(wr_packet),
        .rdrq_packet(rdrq_packet),
        .rdrs_packet(rdrs_packet)
    );

endmodule

// File: logic/glb_host_ctrl.sv
// host side FSM that turns commands into chain packets and collects read data or a timeout
`timescale 1ns/1ps

module glb_host_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_en,
    input  logic                  cmd_valid,
    input  logic                  cmd_wr,
    input  glb_pkg::glb_addr_t    cmd_addr,
    input  glb_pkg::glb_data_t    cmd_wr_data,
    input  glb_pkg::rdrs_packet_t rsp_packet,
    input  logic                  expired,
    output glb_pkg::packet_t      req_packet,
    output logic                  rd_start,
    output logic                  busy,
    output logic                  rd_data_valid,
    output logic                  rd_timeout,
    output glb_pkg::glb_data_t    rd_data
);
    import glb_pkg::*;

    host_state_t state_q;

    logic accept;
    logic rsp_hit;
    logic tmo_hit;

    // commands only taken while idle and the chain is moving
    assign accept = (state_q == host_idle) && clk_en && cmd_valid;
    assign rd_start = accept && !cmd_wr;

    // response only counts on a live clk_en cycle since a frozen chain holds it
    assign rsp_hit = (state_q == host_wait_rsp) && clk_en && rsp_packet.rd_data_valid;
    // watchdog wins even with the chain frozen
    assign tmo_hit = (state_q == host_wait_rsp) && expired && !rsp_hit;

    assign busy = (state_q == host_wait_rsp);

    // request packet lives for one clk_en cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_packet <= '0;
        end else if (clk_en) begin
            req_packet <= '0;
            if (accept) begin
                req_packet.wr.wr_en <= cmd_wr;
                req_packet.wr.wr_addr <= cmd_addr;
                req_packet.wr.wr_data <= cmd_wr_data;
                req_packet.rdrq.rd_en <= !cmd_wr;
                req_packet.rdrq.rd_addr <= cmd_addr;
            end
        end
    end

    // FSM plus the end-of-read pulses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= host_idle;
            rd_data_valid <= 1'b0;
            rd_timeout <= 1'b0;
        end else begin
            rd_data_valid <= rsp_hit;
            rd_timeout <= tmo_hit;
            if (rd_start) begin
                state_q <= host_wait_rsp;
            end else if (rsp_hit || tmo_hit) begin
                state_q <= host_idle;
            end
        end
    end

    // read data capture
    always_ff @(posedge clk) begin
        if (rsp_hit) begin
            rd_data <= rsp_packet.rd_data;
        end
    end

    // a read ends exactly one way
    one_end_per_read: assert property (
        @(posedge clk) disable iff (reset)
        !(rd_data_valid && rd_timeout)
    );

endmodule

// File: logic/glb_rd_timer.sv
// read watchdog: armed by a read start, flags expiry after a fixed clock count
`timescale 1ns/1ps

module glb_rd_timer (
    input  logic clk,
    input  logic reset,
    input  logic rd_start,
    input  logic rd_done,
    output logic expired
);
    import glb_pkg::*;

    typedef logic [$clog2(rd_timeout_cycles+1)-1:0] count_t;

    count_t count_q;
    logic armed_q;

    // free-running clock, not clk_en, so a frozen chain still times out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_q <= '0;
            armed_q <= 1'b0;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (rd_start) begin
                count_q <= count_t'(rd_timeout_cycles);
                armed_q <= 1'b1;
            end else if (rd_done) begin
                armed_q <= 1'b0;
            end else if (armed_q) begin
                count_q <= count_q - count_t'(1);
                // last step, fire and disarm
                if (count_q == count_t'(1)) begin
                    expired <= 1'b1;
                    armed_q <= 1'b0;
                end
            end
        end
    end

endmodule

// File: logic/glb_top.sv
// global buffer top: host FSM, read watchdog and the tile chain with its east-end loopback
`timescale 1ns/1ps

module glb_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               clk_en,
    input  logic               cmd_valid,
    input  logic               cmd_wr,
    input  glb_pkg::glb_addr_t cmd_addr,
    input  glb_pkg::glb_data_t cmd_wr_data,
    output logic               busy,
    output logic               rd_data_valid,
    output glb_pkg::glb_data_t rd_data,
    output logic               rd_timeout
);
    import glb_pkg::*;

    // w2e[i] enters tile i from the west, e2w[i] leaves tile i to the west
    packet_t w2e [num_tiles+1];
    packet_t e2w [num_tiles+1];

    logic rd_start;
    logic rd_done;
    logic expired;

    // east end turns around
    assign e2w[num_tiles] = w2e[num_tiles];

    // either way a read ends, stop the watchdog
    assign rd_done = rd_data_valid || rd_timeout;

    glb_host_ctrl i_host (
        .clk(clk),
        .reset(reset),
        .clk_en(clk_en),
        .cmd_valid(cmd_valid),
        .cmd_wr(cmd_wr),
        .cmd_addr(cmd_addr),
        .cmd_wr_data(cmd_wr_data),
        .rsp_packet(e2w[0].rdrs),
        .expired(expired),
        .req_packet(w2e[0]),
        .rd_start(rd_start),
        .busy(busy),
        .rd_data_valid(rd_data_valid),
        .rd_timeout(rd_timeout),
        .rd_data(rd_data)
    );

    glb_rd_timer i_timer (
        .clk(clk),
        .reset(reset),
        .rd_start(rd_start),
        .rd_done(rd_done),
        .expired(expired)
    );

    for (genvar i = 0; i < num_tiles; i++) begin : g_tile
        glb_tile #(
            .tile_id(i)
        ) i_tile (
            .clk(clk),
            .reset(reset),
            .clk_en(clk_en),
            .packet_w2e_wsti(w2e[i]),
            .packet_e2w_esti(e2w[i+1]),
            .packet_w2e_esto(w2e[i+1]),
            .packet_e2w_wsto(e2w[i])
        );
    end

endmodule

// File: verification/glb_tb.sv
// testbench for glb_top with random writes and reads against a reference memory, stalls and timeouts
`timescale 1ns/1ps

module glb_tb;
    import glb_pkg::*;

    localparam int mem_words = 2**(tile_sel_width+bank_addr_width);
    localparam int rd_bound = 2*num_tiles+2;
    localparam int max_cycles = 3000;

    logic clk;
    logic reset;
    logic clk_en;
    logic cmd_valid;
    logic cmd_wr;
    glb_addr_t cmd_addr;
    glb_data_t cmd_wr_data;
    logic busy;
    logic rd_data_valid;
    glb_data_t rd_data;
    logic rd_timeout;

    // reference model and read expectations
    glb_data_t ref_mem [mem_words];
    glb_data_t exp_data;
    logic rsp_expected;
    logic tmo_expected;
    logic [31:0] rng;
    int err_count;
    int tests_passed;
    int tests_failed;
    int cycle_count;

    glb_top i_glb_top (
        .clk(clk),
        .reset(reset),
        .clk_en(clk_en),
        .cmd_valid(cmd_valid),
        .cmd_wr(cmd_wr),
        .cmd_addr(cmd_addr),
        .cmd_wr_data(cmd_wr_data),
        .busy(busy),
        .rd_data_valid(rd_data_valid),
        .rd_data(rd_data),
        .rd_timeout(rd_timeout)
    );

    always #50 clk = ~clk;

    // run limit at about twice the total test length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("run stopped after %0d cycles, the tests did not finish", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
        err_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        err_count++;
    endtask

    // idle outputs right out of reset
    idle_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !busy && !rd_data_valid && !rd_timeout
    ) else report_mismatch("{busy,rd_data_valid,rd_timeout}", 0,
        32'({$sampled(busy), $sampled(rd_data_valid), $sampled(rd_timeout)}));

    // returned data matches the reference
    data_matches: assert property (
        @(posedge clk) disable iff (reset) rd_data_valid |-> rd_data == exp_data
    ) else report_mismatch("rd_data", exp_data, $sampled(rd_data));

    // data only while a read is waiting for it
    valid_expected: assert property (
        @(posedge clk) disable iff (reset) rd_data_valid |-> rsp_expected
    ) else report_failure("rd_data_valid came when no read was waiting for data");

    timeout_expected: assert property (
        @(posedge clk) disable iff (reset) rd_timeout |-> tmo_expected
    ) else report_failure("rd_timeout came when no read was allowed to time out");

    one_end: assert property (@(posedge clk) disable iff (reset) !(rd_data_valid && rd_timeout))
        else report_failure("rd_data_valid and rd_timeout were high together");

    // busy drops with the end pulse
    busy_ends: assert property (
        @(posedge clk) disable iff (reset) (rd_data_valid || rd_timeout) |-> !busy
    ) else report_mismatch("busy", 0, 32'($sampled(busy)));

    // inputs change 10 ns after the edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic issue_cmd(input logic wr, input glb_addr_t addr, input glb_data_t data);
        cmd_valid = 1'b1;
        cmd_wr = wr;
        cmd_addr = addr;
        cmd_wr_data = data;
        step();
        cmd_valid = 1'b0;
    endtask

    task automatic write_word(input glb_addr_t addr, input glb_data_t data);
        issue_cmd(1'b1, addr, data);
        ref_mem[addr] = data;
        // writes never hold the host
        if (busy) begin
            report_mismatch("busy", 0, 32'(busy));
        end
    endtask

    task automatic start_read(input glb_addr_t addr, input logic want_data);
        exp_data = ref_mem[addr];
        rsp_expected = want_data;
        tmo_expected = !want_data;
        issue_cmd(1'b0, addr, '0);
    endtask

    // wait for either end pulse and one more edge so it gets sampled
    task automatic wait_read_end(input int limit);
        int cycles;
        cycles = 0;
        while (!rd_data_valid && !rd_timeout && cycles < limit) begin
            step();
            cycles++;
        end
        if (!rd_data_valid && !rd_timeout) begin
            report_failure($sformatf("read did not end within %0d cycles", limit));
        end
        step();
        rsp_expected = 1'b0;
        tmo_expected = 1'b0;
    endtask

    task automatic read_word(input glb_addr_t addr);
        start_read(addr, 1'b1);
        wait_read_end(rd_bound);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (err_count == err_before) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", name, err_count - err_before);
            tests_failed++;
        end
    endtask

    initial begin
        int err_before;
        int tmo_count;
        int tmo_at;
        glb_addr_t addr;
        glb_data_t data;
        logic is_wr;

        clk = 1'b0;
        reset = 1'b1;
        clk_en = 1'b1;
        cmd_valid = 1'b0;
        cmd_wr = 1'b0;
        cmd_addr = '0;
        cmd_wr_data = '0;
        exp_data = '0;
        rsp_expected = 1'b0;
        tmo_expected = 1'b0;
        rng = 32'h319fe6e9;
        err_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count = 0;
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = '0;
        end
        repeat (3) step();
        reset = 1'b0;
        step();

        // banks come up cleared
        err_before = err_count;
        for (int t = 0; t < num_tiles; t++) begin
            rng = xorshift32(rng);
            read_word({tile_sel_t'(t), bank_addr_t'(rng)});
        end
        finish_test("reset_state", err_before);

        // one word in each even and odd tile
        err_before = err_count;
        for (int t = 0; t < num_tiles; t++) begin
            rng = xorshift32(rng);
            addr = {tile_sel_t'(t), bank_addr_t'(rng)};
            rng = xorshift32(rng);
            write_word(addr, rng);
        end
        for (int t = 0; t < mem_words; t += 2**bank_addr_width + 5) begin
            read_word(glb_addr_t'(t));
        end
        for (int i = 0; i < mem_words; i++) begin
            if (ref_mem[i] != '0) begin
                read_word(glb_addr_t'(i));
            end
        end
        finish_test("tile_write_read", err_before);

        err_before = err_count;
        for (int n = 0; n < 200; n++) begin
            rng = xorshift32(rng);
            addr = glb_addr_t'(rng);
            is_wr = rng[31];
            rng = xorshift32(rng);
            data = rng;
            if (is_wr) begin
                write_word(addr, data);
            end else begin
                read_word(addr);
            end
        end
        finish_test("random_traffic", err_before);

        // write during a pending read is dropped
        err_before = err_count;
        addr = glb_addr_t'(6'h2b);
        write_word(addr, 32'h5a5a_0f0f);
        start_read(addr, 1'b1);
        if (!busy) begin
            report_mismatch("busy", 1, 32'(busy));
        end
        issue_cmd(1'b1, addr, 32'ha5a5_f0f0);
        wait_read_end(rd_bound);
        read_word(addr);
        finish_test("write_while_busy", err_before);

        // chain frozen past the watchdog limit
        err_before = err_count;
        tmo_count = 0;
        tmo_at = 0;
        start_read(glb_addr_t'(6'h37), 1'b0);
        clk_en = 1'b0;
        for (int i = 1; i <= rd_timeout_cycles + 10; i++) begin
            step();
            if (rd_timeout) begin
                tmo_count++;
                tmo_at = i;
            end
        end
        tmo_expected = 1'b0;
        if (tmo_count != 1) begin
            report_failure($sformatf("expected one read timeout, saw %0d", tmo_count));
        end else if (tmo_at != rd_timeout_cycles + 1) begin
            report_mismatch("rd_timeout cycle", rd_timeout_cycles + 1, tmo_at);
        end
        clk_en = 1'b1;
        // let the late response drain out of the chain
        repeat (rd_bound + 2) step();
        read_word(glb_addr_t'(6'h2b));
        finish_test("read_timeout", err_before);

        // short stall stays under the limit
        err_before = err_count;
        start_read(glb_addr_t'(6'h2b), 1'b1);
        clk_en = 1'b0;
        repeat (5) step();
        clk_en = 1'b1;
        wait_read_end(rd_bound);
        finish_test("short_stall", err_before);

        $display("tests passed %0d, failed %0d, errors %0d",
            tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
logic/glb_pkg.sv
logic/glb_proc_router.sv
logic/glb_bank_switch.sv
logic/glb_tile.sv
logic/glb_host_ctrl.sv
logic/glb_rd_timer.sv
logic/glb_top.sv
verification/glb_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run the glb_tb simulation from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module glb_tb -o glb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/glb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
